/* hw/sfuPkg.sv */
// --------------------
// Fixed geometry: 16 page bits plus 8 byte bits, 256 bytes per page
// FIFO depth must stay a power of two
// --------------------
package sfuPkg;

	// Address and data widths
	localparam int pageWidth = 16;
	localparam int byteWidth = 8;
	localparam int wordWidth = 16;

	// Divider and CS hold counter width
	localparam int divWidth = 8;

	// SPI NOR plain read, 3 address bytes, no dummy
	localparam logic [7:0] cmdRead = 8'h03;

	// Read FIFO, 16 words
	localparam int fifoDepthLog = 4;

	localparam int bytesPerPage = 256;

	// --------------------
	// Sequencer states
	// --------------------
	typedef enum logic [2:0]
	{
		idle,
		cmd,
		adr2,
		adr1,
		adr0,
		data,
		csHold,
		done
	} seqState;

endpackage

/* hw/sfmByteIf.sv */
// --------------------
// One SPI byte per en cycle while the engine is idle
// rd holds from the done pulse until the next byte starts
// --------------------
`timescale 1ns/1ps

interface sfmByteIf;
	import sfuPkg::*;

	// Byte to send and byte received
	logic [byteWidth-1:0] wd;
	logic [byteWidth-1:0] rd;
	// Request level, one byte started per idle cycle
	logic en;
	// Low selects the flash
	logic csCtrl;
	// One cycle after the last sample
	logic done;

	// Requester side
	modport master
	(
		output wd, en, csCtrl,
		input rd, done
	);

	// SPI engine side
	modport slave
	(
		input wd, en, csCtrl,
		output rd, done
	);

endinterface

/* hw/ckeGenerator.sv */
// --------------------
// cke every div+1 clocks while en is high
// div is taken only when en rises
// --------------------
`timescale 1ns/1ps

module ckeGenerator
(
	input logic sClk,
	input logic arstN,
	input logic en,
	input logic [sfuPkg::divWidth-1:0] div,
	output logic cke
);
	import sfuPkg::*;

	logic enQ;
	logic [divWidth-1:0] divReg;
	logic [divWidth-1:0] cnt;
	logic [divWidth-1:0] divNow;

	// Rising en uses the live value, later cycles the held one
	assign divNow = (en && !enQ) ? div : divReg;

	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			enQ <= 1'b0;
			divReg <= '0;
			cnt <= '0;
			cke <= 1'b0;
		end
		else
		begin
			enQ <= en;
			// Capture divisor at start of a burst
			if (en && !enQ)
				divReg <= div;

			if (!en)
			begin
				cnt <= '0;
				cke <= 1'b0;
			end
			else if (cnt == divNow)
			begin
				// Terminal count, pulse and restart
				cnt <= '0;
				cke <= 1'b1;
			end
			else
			begin
				cnt <= cnt + 1'b1;
				cke <= 1'b0;
			end
		end
	end

endmodule

/* hw/spiFlashRom.sv */
// --------------------
// SPI mode 0, MSB first, 16 cke edges per byte
// busy must drive the cke divider enable
// --------------------
`timescale 1ns/1ps

module spiFlashRom
(
	input logic sClk,
	input logic arstN,
	sfmByteIf.slave bus,
	input logic cke,
	output logic sck,
	output logic mosi,
	input logic miso,
	output logic cs,
	output logic busy
);
	import sfuPkg::*;

	// Tx bits leave at the top, rx bits enter at the bottom
	logic [byteWidth-1:0] shiftReg;
	// Even count means the next edge rises
	logic [3:0] edgeCnt;
	logic startByte;
	logic riseEdge;
	logic lastEdge;

	assign startByte = !busy && bus.en;
	assign riseEdge = busy && cke && !edgeCnt[0];
	assign lastEdge = busy && cke && (edgeCnt == 4'hF);

	// --------------------
	// Control and pins
	// --------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= 1'b0;
			edgeCnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
			cs <= 1'b1;
			bus.done <= 1'b0;
		end
		else
		begin
			bus.done <= 1'b0;
			// CS tracks request, one clock late
			cs <= bus.csCtrl;

			if (startByte)
			begin
				busy <= 1'b1;
				edgeCnt <= '0;
				// First bit set up before first rising edge
				mosi <= bus.wd[byteWidth-1];
			end
			else if (busy && cke)
			begin
				edgeCnt <= edgeCnt + 1'b1;
				if (!edgeCnt[0])
				begin
					sck <= 1'b1;
				end
				else
				begin
					sck <= 1'b0;
					if (edgeCnt == 4'hF)
					begin
						// Eighth bit already in, byte complete
						busy <= 1'b0;
						bus.done <= 1'b1;
					end
					else
					begin
						// Next bit on the falling edge
						mosi <= shiftReg[byteWidth-1];
					end
				end
			end
		end
	end

	// --------------------
	// Data path
	// --------------------
	always_ff @(posedge sClk)
	begin
		if (startByte)
			shiftReg <= bus.wd;
		else if (riseEdge)
			// Sample miso with the rising sck
			shiftReg <= {shiftReg[byteWidth-2:0], miso};

		// Result held until the next byte ends
		if (lastEdge)
			bus.rd <= shiftReg;
	end

endmodule

/* hw/readFifo.sv */
// --------------------
// Registered read, rvd one clock after re
// Pop on empty is dropped, push on full is dropped
// --------------------
`timescale 1ns/1ps

module readFifo
(
	input logic sClk,
	input logic arstN,
	input logic we,
	input logic [sfuPkg::wordWidth-1:0] wd,
	input logic re,
	output logic [sfuPkg::wordWidth-1:0] rd,
	output logic rvd,
	output logic emp,
	output logic freeLow
);
	import sfuPkg::*;

	logic [wordWidth-1:0] mem [2**fifoDepthLog];
	// Extra top bit tells full from empty
	logic [fifoDepthLog:0] wrPtr;
	logic [fifoDepthLog:0] rdPtr;
	logic [fifoDepthLog:0] used;
	logic full;
	logic doWrite;
	logic doRead;

	assign used = wrPtr - rdPtr;
	assign emp = (wrPtr == rdPtr);
	assign full = used[fifoDepthLog];
	// One or zero entries left
	assign freeLow = used >= (fifoDepthLog+1)'(2**fifoDepthLog - 1);
	assign doWrite = we && !full;
	assign doRead = re && !emp;

	// Pointers and valid strobe
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			rvd <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			rvd <= doRead;
		end
	end

	// Storage and output word
	always_ff @(posedge sClk)
	begin
		if (doWrite)
			mem[wrPtr[fifoDepthLog-1:0]] <= wd;
		if (doRead)
			rd <= mem[rdPtr[fifoDepthLog-1:0]];
	end

endmodule

/* hw/spiFlashReadSequence.sv */
// --------------------
// Reads pages startAdrs..endAdrs with command 0x03, big-endian words
// Stalls between data bytes while the FIFO has under 2 free entries
// --------------------
`timescale 1ns/1ps

module spiFlashReadSequence
(
	input logic sClk,
	input logic arstN,
	sfmByteIf.master bus,
	// FIFO side
	output logic [sfuPkg::wordWidth-1:0] rd,
	output logic rvd,
	output logic emp,
	input logic re,
	// Control
	input logic sfmEn,
	input logic sfmCycleEn,
	input logic [sfuPkg::divWidth-1:0] csHoldTime,
	input logic [sfuPkg::pageWidth-1:0] startAdrs,
	input logic [sfuPkg::pageWidth-1:0] endAdrs,
	// Status
	output logic sfmDone,
	output logic [sfuPkg::pageWidth-1:0] adrsAdd
);
	import sfuPkg::*;

	seqState state;
	logic [pageWidth-1:0] adrs;
	logic [byteWidth-1:0] byteCnt;
	logic [divWidth-1:0] holdCnt;
	// High byte waiting for its partner
	logic [byteWidth-1:0] hiByte;
	// A byte is out at the engine
	logic inFlight;
	logic byteState;
	logic byteDone;
	logic fifoWe;
	logic freeLow;

	assign adrsAdd = adrs;
	assign byteState = state inside {cmd, adr2, adr1, adr0, data};
	assign byteDone = inFlight && bus.done;
	// CS low through the whole command and data burst
	assign bus.csCtrl = !byteState;
	// Odd byte closes a word
	assign fifoWe = (state == data) && byteDone && byteCnt[0];

	// --------------------
	// Byte request
	// --------------------
	// One cycle request, held off while a byte runs
	// Data bytes also wait for FIFO room, sck stays low meanwhile
	assign bus.en = !inFlight && sfmEn && byteState && !((state == data) && freeLow);

	always_comb
	begin
		case (state)
			cmd: bus.wd = cmdRead;
			adr2: bus.wd = adrs[pageWidth-1:byteWidth];
			adr1: bus.wd = adrs[byteWidth-1:0];
			// Byte within page always starts at 0
			default: bus.wd = '0;
		endcase
	end

	// --------------------
	// State machine
	// --------------------
	always_ff @(posedge sClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			adrs <= '0;
			byteCnt <= '0;
			holdCnt <= '0;
			inFlight <= 1'b0;
			sfmDone <= 1'b0;
		end
		else
		begin
			sfmDone <= 1'b0;
			if (bus.en)
				inFlight <= 1'b1;
			else if (bus.done)
				inFlight <= 1'b0;

			case (state)
				idle:
					if (sfmEn)
					begin
						adrs <= startAdrs;
						state <= cmd;
					end
				cmd, adr2, adr1, adr0, data:
					if (!sfmEn && !inFlight)
					begin
						// Stopped between bytes
						state <= idle;
					end
					else if (byteDone)
					begin
						if (!sfmEn)
							state <= idle;
						else
						begin
							case (state)
								cmd: state <= adr2;
								adr2: state <= adr1;
								adr1: state <= adr0;
								adr0:
								begin
									byteCnt <= '0;
									state <= data;
								end
								default:
								begin
									byteCnt <= byteCnt + 1'b1;
									// Page complete, raise CS
									if (byteCnt == byteWidth'(bytesPerPage - 1))
									begin
										holdCnt <= '0;
										state <= csHold;
									end
								end
							endcase
						end
					end
				csHold:
					if (!sfmEn)
						state <= idle;
					else if (holdCnt == csHoldTime)
					begin
						if (adrs == endAdrs)
						begin
							sfmDone <= 1'b1;
							state <= done;
						end
						else
						begin
							adrs <= adrs + 1'b1;
							state <= cmd;
						end
					end
					else
						holdCnt <= holdCnt + 1'b1;
				done:
					// Range finished, wrap or wait for sfmEn low
					if (!sfmEn)
						state <= idle;
					else if (sfmCycleEn)
					begin
						adrs <= startAdrs;
						state <= cmd;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Even byte goes high in the word
	always_ff @(posedge sClk)
	begin
		if ((state == data) && byteDone && !byteCnt[0])
			hiByte <= bus.rd;
	end

	// --------------------
	// Read FIFO
	// --------------------
	readFifo fifo0
	(
		.sClk(sClk),
		.arstN(arstN),
		.we(fifoWe),
		.wd({hiByte, bus.rd}),
		.re(re),
		.rd(rd),
		.rvd(rvd),
		.emp(emp),
		.freeLow(freeLow)
	);

endmodule

/* hw/spiFlashUnit.sv */
// --------------------
// Use the CPU byte port only while sfmEn is low
// sfmDiv is shared by CPU and sequencer bytes
// --------------------
`timescale 1ns/1ps

module spiFlashUnit
(
	input logic sClk,
	input logic arstN,
	// Flash pins
	output logic sfuSck,
	output logic sfuMosi,
	input logic sfuMiso,
	output logic sfuCs,
	// Read FIFO
	output logic [sfuPkg::wordWidth-1:0] rd,
	output logic rvd,
	output logic emp,
	input logic re,
	// Control
	input logic sfmEn,
	input logic sfmCycleEn,
	input logic [sfuPkg::divWidth-1:0] sfmDiv,
	input logic [sfuPkg::divWidth-1:0] sfmCsHoldTime,
	input logic [sfuPkg::pageWidth-1:0] sfmStartAdrs,
	input logic [sfuPkg::pageWidth-1:0] sfmEndAdrs,
	// CPU byte port, for setup commands
	input logic [sfuPkg::byteWidth-1:0] sfmCpuWd,
	input logic sfmCpuEn,
	input logic sfmCpuCsCtrl,
	input logic sfmCpuValid,
	output logic [sfuPkg::byteWidth-1:0] sfmCpuRd,
	output logic sfmCpuDone,
	// Status
	output logic sfmDone,
	output logic [sfuPkg::pageWidth-1:0] sfmAdrsAdd
);

	logic divCke;
	logic spiBusy;

	sfmByteIf seqBus();
	sfmByteIf romBus();

	// --------------------
	// CPU and sequencer merge
	// --------------------
	// CPU byte wins while valid
	assign romBus.wd = sfmCpuValid ? sfmCpuWd : seqBus.wd;
	assign romBus.en = sfmCpuEn | seqBus.en;
	// Either side can pull CS low
	assign romBus.csCtrl = sfmCpuCsCtrl & seqBus.csCtrl;
	// Result fans out to both
	assign seqBus.rd = romBus.rd;
	assign seqBus.done = romBus.done;
	assign sfmCpuRd = romBus.rd;
	assign sfmCpuDone = romBus.done;

	spiFlashReadSequence readSeq
	(
		.sClk(sClk),
		.arstN(arstN),
		.bus(seqBus.master),
		.rd(rd),
		.rvd(rvd),
		.emp(emp),
		.re(re),
		.sfmEn(sfmEn),
		.sfmCycleEn(sfmCycleEn),
		.csHoldTime(sfmCsHoldTime),
		.startAdrs(sfmStartAdrs),
		.endAdrs(sfmEndAdrs),
		.sfmDone(sfmDone),
		.adrsAdd(sfmAdrsAdd)
	);

	spiFlashRom flashRom
	(
		.sClk(sClk),
		.arstN(arstN),
		.bus(romBus.slave),
		.cke(divCke),
		.sck(sfuSck),
		.mosi(sfuMosi),
		.miso(sfuMiso),
		.cs(sfuCs),
		.busy(spiBusy)
	);

	// sck half period of sfmDiv+1 clocks
	ckeGenerator ckeGen
	(
		.sClk(sClk),
		.arstN(arstN),
		.en(spiBusy),
		.div(sfmDiv),
		.cke(divCke)
	);

endmodule

/* sim/flashModel.sv */
// --------------------
// Behavioural SPI NOR, mode 0, plain read 0x03 and status 0x05 only
// Byte at A is A[7:0] ^ A[15:8] ^ A[23:16]
// --------------------
`timescale 1ns/1ps

module flashModel
(
	input logic sck,
	input logic mosi,
	output logic miso,
	input logic cs
);
	import sfuPkg::*;

	logic [7:0] inShift = '0;
	logic [7:0] outShift = '0;
	logic [7:0] cmdByte = '0;
	logic [2:0] bitCnt = '0;
	// Byte index within the CS frame, stops at 4
	logic [2:0] byteIdx = '0;
	logic [23:0] adrs = '0;

	initial
		miso = 1'b0;

	function automatic logic [7:0] romByte(input logic [23:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16];
	endfunction

	always @(posedge sck or negedge sck or posedge cs)
	begin
		if (cs)
		begin
			// Deselect ends the frame
			bitCnt = '0;
			byteIdx = '0;
			outShift = '0;
		end
		else if (sck)
		begin
			// Sample mosi on the rising edge
			inShift = {inShift[6:0], mosi};
			bitCnt = bitCnt + 3'd1;
			if (bitCnt == 3'd0)
			begin
				case (byteIdx)
					3'd0:
					begin
						cmdByte = inShift;
						// Status answer goes out in the next byte
						outShift = (inShift == 8'h05) ? 8'h5A : 8'h00;
					end
					3'd1: adrs[23:16] = inShift;
					3'd2: adrs[15:8] = inShift;
					default:
					begin
						if (byteIdx == 3'd3)
							adrs[7:0] = inShift;
						if (cmdByte == cmdRead)
						begin
							outShift = romByte(adrs);
							adrs = adrs + 24'd1;
						end
						else
							outShift = 8'h00;
					end
				endcase
				if (byteIdx != 3'd4)
					byteIdx = byteIdx + 3'd1;
			end
		end
		else
		begin
			// Next bit out on the falling edge
			miso = outShift[7];
			outShift = {outShift[6:0], 1'b0};
		end
	end

endmodule

/* sim/tbSpiFlashUnit.sv */
// --------------------
// All runs share one reset and the same flash content rule
// Expected words come from page, offset and the range only
// --------------------
`timescale 1ns/1ps

module tbSpiFlashUnit;
	import sfuPkg::*;

	// Longest runs take about 75000 clocks, margin of over two
	localparam int timeoutCycles = 200000;

	logic sClk = 1'b0;
	logic arstN = 1'b0;
	logic sfuSck, sfuMosi, sfuMiso, sfuCs;
	logic [15:0] rd;
	logic rvd, emp;
	logic re = 1'b0;
	logic sfmEn = 1'b0;
	logic sfmCycleEn = 1'b0;
	logic [7:0] sfmDiv = 8'd1;
	logic [7:0] sfmCsHoldTime = 8'd0;
	logic [15:0] sfmStartAdrs = 16'd0;
	logic [15:0] sfmEndAdrs = 16'd0;
	logic [7:0] sfmCpuWd = 8'd0;
	logic sfmCpuEn = 1'b0;
	logic sfmCpuCsCtrl = 1'b1;
	logic sfmCpuValid = 1'b0;
	logic [7:0] sfmCpuRd;
	logic sfmCpuDone, sfmDone;
	logic [15:0] sfmAdrsAdd;

	int errCount = 0;
	int cycles = 0;
	int wordCnt = 0;
	int doneCnt = 0;
	int cpuDoneCnt = 0;
	int runBase = 0;
	int doneBase = 0;
	// 0 hold re low, 1 pop always, 2 random gaps
	int reMode = 0;
	int phaseLen = 0;
	int csLen = 0;
	int riseCnt = 0;
	logic sckQ = 1'b0;
	logic csQ = 1'b1;
	logic stallWin = 1'b0;
	logic divCheck = 1'b0;
	logic cpuCheck = 1'b0;
	logic [15:0] expWord;
	string testName = "reset";

	spiFlashUnit dut0
	(
		.sClk(sClk), .arstN(arstN),
		.sfuSck(sfuSck), .sfuMosi(sfuMosi), .sfuMiso(sfuMiso), .sfuCs(sfuCs),
		.rd(rd), .rvd(rvd), .emp(emp), .re(re),
		.sfmEn(sfmEn), .sfmCycleEn(sfmCycleEn), .sfmDiv(sfmDiv),
		.sfmCsHoldTime(sfmCsHoldTime), .sfmStartAdrs(sfmStartAdrs), .sfmEndAdrs(sfmEndAdrs),
		.sfmCpuWd(sfmCpuWd), .sfmCpuEn(sfmCpuEn), .sfmCpuCsCtrl(sfmCpuCsCtrl),
		.sfmCpuValid(sfmCpuValid), .sfmCpuRd(sfmCpuRd), .sfmCpuDone(sfmCpuDone),
		.sfmDone(sfmDone), .sfmAdrsAdd(sfmAdrsAdd)
	);

	flashModel flash0(.sck(sfuSck), .mosi(sfuMosi), .miso(sfuMiso), .cs(sfuCs));

	always #2 sClk = ~sClk;

	// --------------------
	// Reference data
	// --------------------
	function automatic logic [7:0] flashByte(input logic [15:0] page, input logic [7:0] offset);
		return offset ^ page[7:0] ^ page[15:8];
	endfunction

	// Word idx of a run, wrapping over the page range
	function automatic logic [15:0] expectWord(input logic [15:0] first,
		input logic [15:0] last, input int idx);
		int pages;
		logic [15:0] page;
		logic [7:0] offset;
		pages = int'(last) - int'(first) + 1;
		page = first + 16'((idx / 128) % pages);
		offset = 8'((idx % 128) * 2);
		return {flashByte(page, offset), flashByte(page, offset + 8'd1)};
	endfunction

	assign expWord = expectWord(sfmStartAdrs, sfmEndAdrs, wordCnt - runBase);

	// Strobe counters and sck/cs phase lengths
	always @(posedge sClk)
	begin
		if (rvd)
			wordCnt <= wordCnt + 1;
		if (sfmDone)
			doneCnt <= doneCnt + 1;
		if (cpuCheck && sfmCpuDone)
			cpuDoneCnt <= cpuDoneCnt + 1;
		sckQ <= sfuSck;
		csQ <= sfuCs;
		if (sfuSck != sckQ)
		begin
			phaseLen <= 1;
			if (sfuSck)
				riseCnt <= riseCnt + 1;
		end
		else
			phaseLen <= phaseLen + 1;
		if (sfuCs != csQ)
			csLen <= 1;
		else
			csLen <= csLen + 1;
	end

	// Pop pattern, driven after the edge
	always @(posedge sClk)
	begin
		#1;
		case (reMode)
			0: re = 1'b0;
			1: re = 1'b1;
			default: re = ($urandom % 3) == 0;
		endcase
	end

	always @(posedge sClk)
	begin
		cycles <= cycles + 1;
		if (cycles == timeoutCycles)
		begin
			$display("timeout in %s after %0d cycles", testName, cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic reportMismatch(input string name, input int expected, input int actual);
		errCount++;
		$display("error %s expected %0h actual %0h", name, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		errCount++;
		$display("%s: %s", testName, what);
	endtask

	// --------------------
	// Checks
	// --------------------
	wordOrder: assert property (@(posedge sClk) disable iff (!arstN) rvd |-> rd == expWord)
		else reportMismatch(testName, int'(expWord), int'(rd));
	doneAdrs: assert property (@(posedge sClk) disable iff (!arstN)
		sfmDone |-> sfmAdrsAdd == sfmEndAdrs)
		else reportMismatch(testName, int'(sfmEndAdrs), int'(sfmAdrsAdd));
	cpuStatus: assert property (@(posedge sClk) disable iff (!arstN)
		cpuCheck && sfmCpuDone && cpuDoneCnt == 1 |-> sfmCpuRd == 8'h5A)
		else reportMismatch(testName, 'h5A, int'(sfmCpuRd));
	stallQuiet: assert property (@(posedge sClk) disable iff (!arstN)
		stallWin |-> !sfuSck && !sfuCs)
		else reportFailure("sck moved or CS rose while the FIFO was full");
	// Low phase before the first rise of a byte spans the byte gap
	sckPhase: assert property (@(posedge sClk) disable iff (!arstN)
		divCheck && sfuSck != sckQ && (sckQ || riseCnt % 8 != 0)
		|-> phaseLen == int'(sfmDiv) + 1)
		else reportMismatch(testName, int'(sfmDiv) + 1, phaseLen);
	csGap: assert property (@(posedge sClk) disable iff (!arstN)
		divCheck && !sfuCs && csQ |-> csLen >= int'(sfmCsHoldTime) + 1)
		else reportFailure("CS high gap shorter than the hold time");

	// --------------------
	// Stimulus helpers
	// --------------------
	task automatic stepCycles(input int n);
		repeat (n) @(posedge sClk);
		#1;
	endtask

	task automatic sendCpuByte(input logic [7:0] b);
		sfmCpuWd = b;
		sfmCpuValid = 1'b1;
		sfmCpuEn = 1'b1;
		@(posedge sClk);
		#1 sfmCpuEn = 1'b0;
		do
			@(posedge sClk);
		while (!sfmCpuDone);
		#1;
	endtask

	task automatic startRun(input string name, input logic [15:0] first, input logic [15:0] last,
		input logic [7:0] div, input logic [7:0] hold, input logic cycle);
		testName = name;
		sfmStartAdrs = first;
		sfmEndAdrs = last;
		sfmDiv = div;
		sfmCsHoldTime = hold;
		sfmCycleEn = cycle;
		runBase = wordCnt;
		doneBase = doneCnt;
		sfmEn = 1'b1;
	endtask

	task automatic waitDonePulses(input int n);
		while (doneCnt - doneBase < n)
			@(posedge sClk);
		#1;
	endtask

	task automatic waitWords(input int n);
		while (wordCnt - runBase < n)
			@(posedge sClk);
		#1;
	endtask

	task automatic finishRun(input int words, input int pulses);
		stepCycles(100);
		assert (wordCnt - runBase == words)
			else reportMismatch({testName, " words"}, words, wordCnt - runBase);
		assert (doneCnt - doneBase == pulses)
			else reportMismatch({testName, " done pulses"}, pulses, doneCnt - doneBase);
		assert (emp)
			else reportFailure("FIFO not empty after all words were popped");
		sfmEn = 1'b0;
		sfmCycleEn = 1'b0;
		stepCycles(20);
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin
		void'($urandom(62));
		repeat (4) @(posedge sClk);
		#1 arstN = 1'b1;
		stepCycles(2);

		// Status read through the CPU port
		testName = "cpuPath";
		cpuCheck = 1'b1;
		sfmCpuCsCtrl = 1'b0;
		stepCycles(1);
		sendCpuByte(8'h05);
		sendCpuByte(8'h00);
		stepCycles(2);
		assert (cpuDoneCnt == 2)
			else reportMismatch("cpuPath done pulses", 2, cpuDoneCnt);
		cpuCheck = 1'b0;
		sfmCpuCsCtrl = 1'b1;
		sfmCpuValid = 1'b0;
		stepCycles(10);

		// Range read, FIFO fills first, then random pops
		reMode = 0;
		startRun("rangeRead", 16'd3, 16'd4, 8'd1, 8'd2, 1'b0);
		stepCycles(1500);
		stallWin = 1'b1;
		stepCycles(500);
		stallWin = 1'b0;
		reMode = 2;
		waitDonePulses(1);
		waitWords(256);
		finishRun(256, 1);

		// Slower sck and longer CS gap
		reMode = 1;
		startRun("clockDivider", 16'd7, 16'd8, 8'd3, 8'd5, 1'b0);
		divCheck = 1'b1;
		waitDonePulses(1);
		waitWords(256);
		divCheck = 1'b0;
		finishRun(256, 1);

		// Two passes over the range
		startRun("cycleMode", 16'd10, 16'd11, 8'd0, 8'd1, 1'b1);
		waitDonePulses(2);
		sfmEn = 1'b0;
		sfmCycleEn = 1'b0;
		finishRun(512, 2);

		$display("words %0d, done pulses %0d, errors %0d", wordCnt, doneCnt, errCount);
		if (errCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* vlog.f */
hw/sfuPkg.sv
hw/sfmByteIf.sv
hw/ckeGenerator.sv
hw/spiFlashRom.sv
hw/readFifo.sv
hw/spiFlashReadSequence.sv
hw/spiFlashUnit.sv
sim/flashModel.sv
sim/tbSpiFlashUnit.sv

/* Makefile */
# Verilator build and run of the SPI flash unit testbench

TOP := tbSpiFlashUnit

all: run

obj_dir/V$(TOP): vlog.f $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module spiFlashUnit

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
